// File: Makefile
TOP = RasterixTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: flist.f
+incdir+sim
rtl/CmdPkg.sv
rtl/PixelPkg.sv
rtl/CommandParser.sv
rtl/RegisterBank.sv
rtl/Rasterizer.sv
rtl/FrameBuffer.sv
rtl/Rasterix.sv
sim/RasterixTb.sv

// File: rtl/CmdPkg.sv
package CmdPkg;

    // One word of the command stream
    typedef logic [15:0] cmdWord_t;

    // Register index, header bits 3 to 0
    typedef logic [3:0] regIndex_t;

    // Opcodes, header bits 15 to 12
    localparam logic [3:0] OpRegWrite = 4'h1;
    localparam logic [3:0] OpStart    = 4'h2;
    localparam logic [3:0] OpMemset   = 4'h3;
    localparam logic [3:0] OpCommit   = 4'h4;

    // Triangle and configuration registers
    localparam regIndex_t RegBbStart    = 4'd0;
    localparam regIndex_t RegBbEnd      = 4'd1;
    localparam regIndex_t RegW0         = 4'd2;
    localparam regIndex_t RegW1         = 4'd3;
    localparam regIndex_t RegW2         = 4'd4;
    localparam regIndex_t RegW0IncX     = 4'd5;
    localparam regIndex_t RegW1IncX     = 4'd6;
    localparam regIndex_t RegW2IncX     = 4'd7;
    localparam regIndex_t RegW0IncY     = 4'd8;
    localparam regIndex_t RegW1IncY     = 4'd9;
    localparam regIndex_t RegW2IncY     = 4'd10;
    localparam regIndex_t RegColor      = 4'd11;
    localparam regIndex_t RegColorMask  = 4'd12;
    localparam regIndex_t RegClearColor = 4'd13;

    localparam int NumRegs = 14;

endpackage

// File: rtl/CommandParser.sv
`timescale 1ns/1ns

module CommandParser (
    input  logic                  aclk,
    input  logic                  rst,

    // Command stream
    input  logic                  cmdValid,
    output logic                  cmdReady,
    input  logic                  cmdLast,
    input  CmdPkg::cmdWord_t      cmdData,

    // Register bank
    output logic                  regWrite,
    output CmdPkg::regIndex_t     regIndex,
    output CmdPkg::cmdWord_t      regData,

    // Rasterizer and frame buffer control
    output logic                  startRendering,
    input  logic                  rasterizerRunning,
    output logic                  memsetStart,
    output logic                  commitStart,
    input  logic                  fbBusy
);

    typedef enum logic [1:0] {
        Idle,
        RegData,
        WaitDone
    } state_t;

    state_t     state;
    logic       accept;
    logic       header;
    logic [3:0] opcode;

    // Packet framing lives in the opcodes, cmdLast carries no meaning here
    assign cmdReady = (state != WaitDone);
    assign accept   = cmdValid && cmdReady;
    assign header   = accept && (state == Idle);
    assign opcode   = cmdData[15:12];

    // Strobes fire in the accept cycle so the busy levels are up one cycle later
    assign startRendering = header && (opcode == CmdPkg::OpStart);
    assign memsetStart    = header && (opcode == CmdPkg::OpMemset);
    assign commitStart    = header && (opcode == CmdPkg::OpCommit);

    assign regWrite = accept && (state == RegData);
    assign regData  = cmdData;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            case (state)
                Idle: begin
                    if (header) begin
                        if (opcode == CmdPkg::OpRegWrite) begin
                            state <= RegData;
                        end else if (startRendering || memsetStart || commitStart) begin
                            state <= WaitDone;
                        end
                        // Anything else is dropped
                    end
                end
                RegData: begin
                    if (accept) begin
                        state <= Idle;
                    end
                end
                WaitDone: begin
                    if (!rasterizerRunning && !fbBusy) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Index is kept from the header until the data word arrives
    always_ff @(posedge aclk) begin
        if (header && (opcode == CmdPkg::OpRegWrite)) begin
            regIndex <= cmdData[3:0];
        end
    end

endmodule

// File: rtl/FrameBuffer.sv
`timescale 1ns/1ns

module FrameBuffer #(
    parameter  int xResolution = 16,
    parameter  int yResolution = 16,
    localparam int PixelCount  = xResolution * yResolution,
    localparam int IndexWidth  = $clog2(PixelCount)
) (
    input  logic                     aclk,
    input  logic                     rst,

    // Pixel writes from the rasterizer
    input  logic                     pixelWrite,
    input  logic [IndexWidth-1:0]    pixelIndex,
    input  PixelPkg::color_t         pixelColor,
    input  PixelPkg::colorMask_t     pixelMask,

    // Control
    input  logic                     memsetStart,
    input  logic                     commitStart,
    input  PixelPkg::color_t         clearColor,
    output logic                     fbBusy,

    // Frame stream
    output logic                     fbValid,
    input  logic                     fbReady,
    output logic                     fbLast,
    output PixelPkg::color_t         fbData
);

    localparam logic [IndexWidth-1:0] LastIndex = IndexWidth'(PixelCount - 1);

    typedef enum logic [1:0] {
        Idle,
        Clearing,
        Streaming
    } state_t;

    state_t                 state;
    PixelPkg::color_t       mem [PixelCount];
    // Clear address or read address depending on the state
    logic [IndexWidth-1:0]  idx;
    logic                   allRead;
    logic                   advance;
    logic                   clearing;
    logic                   wrEn;
    logic [IndexWidth-1:0]  wrIdx;
    PixelPkg::color_t       wrData;
    PixelPkg::colorMask_t   wrMask;

    assign fbBusy   = (state != Idle);
    assign clearing = (state == Clearing);

    // Clear overrides the mask and owns the write port while it runs
    assign wrEn   = pixelWrite || clearing;
    assign wrIdx  = clearing ? idx : pixelIndex;
    assign wrData = clearing ? clearColor : pixelColor;
    assign wrMask = clearing ? 4'hf : pixelMask;

    // Read only while the output word is empty or being taken
    assign advance = (state == Streaming) && !allRead && (!fbValid || fbReady);

    ////////////////////////////////////////////////////////////////////
    // Colour memory with nibble write enables and registered read
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        for (int n = 0; n < 4; n++) begin
            if (wrEn && wrMask[n]) begin
                mem[wrIdx][n*4 +: 4] <= wrData[n*4 +: 4];
            end
        end
        // Read register doubles as the holding stage under stall
        if (advance) begin
            fbData <= mem[idx];
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= Idle;
            idx     <= '0;
            allRead <= 1'b0;
            fbValid <= 1'b0;
            fbLast  <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    idx     <= '0;
                    allRead <= 1'b0;
                    fbLast  <= 1'b0;
                    if (memsetStart) begin
                        state <= Clearing;
                    end else if (commitStart) begin
                        state <= Streaming;
                    end
                end
                Clearing: begin
                    idx <= idx + IndexWidth'(1);
                    if (idx == LastIndex) begin
                        state <= Idle;
                    end
                end
                Streaming: begin
                    if (advance) begin
                        idx     <= idx + IndexWidth'(1);
                        allRead <= (idx == LastIndex);
                        fbValid <= 1'b1;
                        fbLast  <= (idx == LastIndex);
                    end else if (fbReady) begin
                        fbValid <= 1'b0;
                    end
                    if (fbValid && fbReady && fbLast) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

// File: rtl/PixelPkg.sv
package PixelPkg;

    // Screen coordinate
    // Bounding box words carry y in the high byte, x in the low byte
    typedef logic [7:0] coord_t;

    // Edge function value, two's complement, wraps at 16 bits
    typedef logic [15:0] edge_t;

    // RGBA4444 pixel, R in bits 15 to 12, A in bits 3 to 0
    typedef logic [15:0] color_t;

    // Per-channel write enable
    // Bit 3 enables R and bit 0 enables A, same order as color_t
    typedef logic [3:0] colorMask_t;

endpackage

// File: rtl/Rasterix.sv
`timescale 1ns/1ns

module Rasterix #(
    parameter int xResolution = 16,
    parameter int yResolution = 16
) (
    input  logic                 aclk,
    input  logic                 rst,

    // Command stream in
    input  logic                 cmdValid,
    output logic                 cmdReady,
    input  logic                 cmdLast,
    input  CmdPkg::cmdWord_t     cmdData,

    // Frame stream out
    output logic                 fbValid,
    input  logic                 fbReady,
    output logic                 fbLast,
    output PixelPkg::color_t     fbData
);

    localparam int IndexWidth = $clog2(xResolution * yResolution);

    ////////////////////////////////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////////////////////////////////
    logic                    regWrite;
    CmdPkg::regIndex_t       regIndex;
    CmdPkg::cmdWord_t        regData;
    logic                    startRendering;
    logic                    rasterizerRunning;
    logic                    memsetStart;
    logic                    commitStart;
    logic                    fbBusy;

    CmdPkg::cmdWord_t        bbStart;
    CmdPkg::cmdWord_t        bbEnd;
    PixelPkg::edge_t         w0;
    PixelPkg::edge_t         w1;
    PixelPkg::edge_t         w2;
    PixelPkg::edge_t         w0IncX;
    PixelPkg::edge_t         w1IncX;
    PixelPkg::edge_t         w2IncX;
    PixelPkg::edge_t         w0IncY;
    PixelPkg::edge_t         w1IncY;
    PixelPkg::edge_t         w2IncY;
    PixelPkg::color_t        color;
    PixelPkg::color_t        clearColor;
    PixelPkg::colorMask_t    colorMask;

    // Rasterizer to colour buffer
    logic                    pixelWrite;
    logic [IndexWidth-1:0]   pixelIndex;
    PixelPkg::color_t        pixelColor;
    PixelPkg::colorMask_t    pixelMask;

    CommandParser u_CommandParser (
        .aclk(aclk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdLast(cmdLast),
        .cmdData(cmdData),
        .regWrite(regWrite),
        .regIndex(regIndex),
        .regData(regData),
        .startRendering(startRendering),
        .rasterizerRunning(rasterizerRunning),
        .memsetStart(memsetStart),
        .commitStart(commitStart),
        .fbBusy(fbBusy)
    );

    RegisterBank u_RegisterBank (
        .aclk(aclk),
        .rst(rst),
        .regWrite(regWrite),
        .regIndex(regIndex),
        .regData(regData),
        .bbStart(bbStart),
        .bbEnd(bbEnd),
        .w0(w0),
        .w1(w1),
        .w2(w2),
        .w0IncX(w0IncX),
        .w1IncX(w1IncX),
        .w2IncX(w2IncX),
        .w0IncY(w0IncY),
        .w1IncY(w1IncY),
        .w2IncY(w2IncY),
        .color(color),
        .clearColor(clearColor),
        .colorMask(colorMask)
    );

    Rasterizer #(
        .xResolution(xResolution),
        .yResolution(yResolution)
    ) u_Rasterizer (
        .aclk(aclk),
        .rst(rst),
        .startRendering(startRendering),
        .rasterizerRunning(rasterizerRunning),
        .bbStart(bbStart),
        .bbEnd(bbEnd),
        .w0(w0),
        .w1(w1),
        .w2(w2),
        .w0IncX(w0IncX),
        .w1IncX(w1IncX),
        .w2IncX(w2IncX),
        .w0IncY(w0IncY),
        .w1IncY(w1IncY),
        .w2IncY(w2IncY),
        .color(color),
        .colorMask(colorMask),
        .pixelWrite(pixelWrite),
        .pixelIndex(pixelIndex),
        .pixelColor(pixelColor),
        .pixelMask(pixelMask)
    );

    FrameBuffer #(
        .xResolution(xResolution),
        .yResolution(yResolution)
    ) u_FrameBuffer (
        .aclk(aclk),
        .rst(rst),
        .pixelWrite(pixelWrite),
        .pixelIndex(pixelIndex),
        .pixelColor(pixelColor),
        .pixelMask(pixelMask),
        .memsetStart(memsetStart),
        .commitStart(commitStart),
        .clearColor(clearColor),
        .fbBusy(fbBusy),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData)
    );

endmodule

// File: rtl/Rasterizer.sv
`timescale 1ns/1ns

module Rasterizer #(
    parameter  int xResolution = 16,
    parameter  int yResolution = 16,
    localparam int IndexWidth  = $clog2(xResolution * yResolution)
) (
    input  logic                     aclk,
    input  logic                     rst,

    input  logic                     startRendering,
    output logic                     rasterizerRunning,

    input  CmdPkg::cmdWord_t         bbStart,
    input  CmdPkg::cmdWord_t         bbEnd,
    input  PixelPkg::edge_t          w0,
    input  PixelPkg::edge_t          w1,
    input  PixelPkg::edge_t          w2,
    input  PixelPkg::edge_t          w0IncX,
    input  PixelPkg::edge_t          w1IncX,
    input  PixelPkg::edge_t          w2IncX,
    input  PixelPkg::edge_t          w0IncY,
    input  PixelPkg::edge_t          w1IncY,
    input  PixelPkg::edge_t          w2IncY,
    input  PixelPkg::color_t         color,
    input  PixelPkg::colorMask_t     colorMask,

    output logic                     pixelWrite,
    output logic [IndexWidth-1:0]    pixelIndex,
    output PixelPkg::color_t         pixelColor,
    output PixelPkg::colorMask_t     pixelMask
);

    typedef enum logic {
        Idle,
        Walking
    } state_t;

    state_t           state;
    PixelPkg::coord_t x;
    PixelPkg::coord_t y;
    PixelPkg::coord_t startX;
    PixelPkg::coord_t startY;
    PixelPkg::coord_t endX;
    PixelPkg::coord_t endY;
    PixelPkg::edge_t  wStart  [3];
    PixelPkg::edge_t  incX    [3];
    PixelPkg::edge_t  incY    [3];
    // Edge values at the current pixel and at the first pixel of the row
    PixelPkg::edge_t  edgeVal [3];
    PixelPkg::edge_t  rowVal  [3];
    logic             covered;

    assign startX = bbStart[7:0];
    assign startY = bbStart[15:8];
    assign endX   = bbEnd[7:0];
    assign endY   = bbEnd[15:8];
    assign wStart = '{w0, w1, w2};
    assign incX   = '{w0IncX, w1IncX, w2IncX};
    assign incY   = '{w0IncY, w1IncY, w2IncY};

    // Inside when no edge function went negative
    assign covered = !edgeVal[0][15] && !edgeVal[1][15] && !edgeVal[2][15];

    assign rasterizerRunning = (state == Walking);
    assign pixelWrite = rasterizerRunning && covered
                        && (int'(x) < xResolution) && (int'(y) < yResolution);
    assign pixelIndex = IndexWidth'(int'(y) * xResolution + int'(x));
    assign pixelColor = color;
    assign pixelMask  = colorMask;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            case (state)
                Idle:    if (startRendering) state <= Walking;
                Walking: if ((x == endX) && (y == endY)) state <= Idle;
                default: state <= Idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Box walk, one pixel per cycle in row order
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (state == Idle) begin
            if (startRendering) begin
                x       <= startX;
                y       <= startY;
                edgeVal <= wStart;
                rowVal  <= wStart;
            end
        end else if (x != endX) begin
            x <= x + 8'd1;
            for (int i = 0; i < 3; i++) begin
                edgeVal[i] <= edgeVal[i] + incX[i];
            end
        end else begin
            // Next row restarts from the row start plus one Y step
            x <= startX;
            y <= y + 8'd1;
            for (int i = 0; i < 3; i++) begin
                rowVal[i]  <= rowVal[i] + incY[i];
                edgeVal[i] <= rowVal[i] + incY[i];
            end
        end
    end

endmodule

// File: rtl/RegisterBank.sv
`timescale 1ns/1ns

module RegisterBank (
    input  logic                  aclk,
    input  logic                  rst,

    input  logic                  regWrite,
    input  CmdPkg::regIndex_t     regIndex,
    input  CmdPkg::cmdWord_t      regData,

    output CmdPkg::cmdWord_t      bbStart,
    output CmdPkg::cmdWord_t      bbEnd,
    output PixelPkg::edge_t       w0,
    output PixelPkg::edge_t       w1,
    output PixelPkg::edge_t       w2,
    output PixelPkg::edge_t       w0IncX,
    output PixelPkg::edge_t       w1IncX,
    output PixelPkg::edge_t       w2IncX,
    output PixelPkg::edge_t       w0IncY,
    output PixelPkg::edge_t       w1IncY,
    output PixelPkg::edge_t       w2IncY,
    output PixelPkg::color_t      color,
    output PixelPkg::color_t      clearColor,
    output PixelPkg::colorMask_t  colorMask
);

    CmdPkg::cmdWord_t regs [CmdPkg::NumRegs];

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < CmdPkg::NumRegs; i++) begin
                regs[i] <= '0;
            end
            // All channels writable out of reset
            regs[CmdPkg::RegColorMask] <= 16'h000f;
        end else if (regWrite && (int'(regIndex) < CmdPkg::NumRegs)) begin
            regs[regIndex] <= regData;
        end
    end

    assign bbStart    = regs[CmdPkg::RegBbStart];
    assign bbEnd      = regs[CmdPkg::RegBbEnd];
    assign w0         = regs[CmdPkg::RegW0];
    assign w1         = regs[CmdPkg::RegW1];
    assign w2         = regs[CmdPkg::RegW2];
    assign w0IncX     = regs[CmdPkg::RegW0IncX];
    assign w1IncX     = regs[CmdPkg::RegW1IncX];
    assign w2IncX     = regs[CmdPkg::RegW2IncX];
    assign w0IncY     = regs[CmdPkg::RegW0IncY];
    assign w1IncY     = regs[CmdPkg::RegW1IncY];
    assign w2IncY     = regs[CmdPkg::RegW2IncY];
    assign color      = regs[CmdPkg::RegColor];
    assign clearColor = regs[CmdPkg::RegClearColor];
    assign colorMask  = regs[CmdPkg::RegColorMask][3:0];

endmodule

// File: sim/RasterixTbTasks.svh
// Command words are driven after a falling edge and taken on the next rising edge
task automatic sendWord(input CmdPkg::cmdWord_t word);
    int waited;
    bit taken;
    waited = 0;
    taken = 1'b0;
    if (gapsOn) begin
        repeat ($urandom_range(2)) @(negedge aclk);
    end
    cmdValid = 1'b1;
    cmdData = word;
    while (!taken && waited < CmdTimeout) begin
        // cmdReady only follows the parser state, steady until the edge
        taken = cmdReady;
        @(negedge aclk);
        waited++;
    end
    cmdValid = 1'b0;
    if (!taken) begin
        $display("Command word %h was not accepted within %0d cycles", word, CmdTimeout);
        abortRun();
    end
endtask

task automatic writeReg(input CmdPkg::regIndex_t idx, input CmdPkg::cmdWord_t value);
    sendWord({CmdPkg::OpRegWrite, 8'h00, idx});
    sendWord(value);
endtask

task automatic sendOp(input logic [3:0] op);
    sendWord({op, 12'h000});
endtask

////////////////////////////////////////////////////////////////////
// Frame collection, compared beat by beat against the model
////////////////////////////////////////////////////////////////////
task automatic collectFrame(input string test, input bit stalls);
    int beats;
    int waited;
    beats = 0;
    waited = 0;
    while (beats < PixelCount && waited < FrameTimeout) begin
        fbReady = stalls ? ($urandom_range(3) != 0) : 1'b1;
        if (fbValid && fbReady) begin
            checkEqual($sformatf("%s last %0d", test, beats),
                       16'(beats == PixelCount - 1), 16'(fbLast));
            checkEqual($sformatf("%s pixel %0d", test, beats), model[beats], fbData);
            beats++;
        end
        @(negedge aclk);
        waited++;
    end
    fbReady = 1'b0;
    if (beats < PixelCount) begin
        $display("Frame %s: only %0d of %0d beats arrived in time", test, beats, PixelCount);
        abortRun();
    end
    // No beat after the one carrying fbLast
    checkEqual({test, " extra beat"}, 16'h0000, 16'(fbValid));
endtask

// File: sim/RasterixTb.sv
`timescale 1ns/1ns

module RasterixTb;

    localparam int PixelCount   = 256;
    localparam int CmdTimeout   = 1000;
    localparam int FrameTimeout = 2000;

    logic             aclk;
    logic             rst;
    logic             cmdValid;
    logic             cmdReady;
    logic             cmdLast;
    CmdPkg::cmdWord_t cmdData;
    logic             fbValid;
    logic             fbReady;
    logic             fbLast;
    PixelPkg::color_t fbData;

    // Expected colour buffer
    PixelPkg::color_t model [PixelCount];
    // Edge setup of the next triangle
    PixelPkg::edge_t  triW    [3];
    PixelPkg::edge_t  triIncX [3];
    PixelPkg::edge_t  triIncY [3];
    bit               gapsOn;

    Rasterix #(
        .xResolution(16),
        .yResolution(16)
    ) u_Rasterix (
        .aclk(aclk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdLast(cmdLast),
        .cmdData(cmdData),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData)
    );

    always #50 aclk = ~aclk;

    task automatic abortRun();
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkEqual(input string test, input logic [15:0] expected,
                              input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("Error %s: expected %h, actual %h", test, expected, actual);
            abortRun();
        end
    endtask

    `include "RasterixTbTasks.svh"

    ////////////////////////////////////////////////////////////////////
    // Frame model
    ////////////////////////////////////////////////////////////////////
    function automatic void clearModel(input PixelPkg::color_t col);
        for (int i = 0; i < PixelCount; i++) begin
            model[i] = col;
        end
    endfunction

    function automatic void renderModel(input CmdPkg::cmdWord_t bbS, input CmdPkg::cmdWord_t bbE,
                                        input PixelPkg::color_t col,
                                        input PixelPkg::colorMask_t mask);
        PixelPkg::edge_t e [3];
        int dx;
        int dy;
        int idx;
        for (int y = int'(bbS[15:8]); y <= int'(bbE[15:8]); y++) begin
            for (int x = int'(bbS[7:0]); x <= int'(bbE[7:0]); x++) begin
                dx = x - int'(bbS[7:0]);
                dy = y - int'(bbS[15:8]);
                idx = y * 16 + x;
                for (int i = 0; i < 3; i++) begin
                    e[i] = 16'(triW[i] + dx * triIncX[i] + dy * triIncY[i]);
                end
                // Covered when no sign bit is set
                if (!e[0][15] && !e[1][15] && !e[2][15]) begin
                    for (int n = 0; n < 4; n++) begin
                        if (mask[n]) begin
                            model[idx][n*4 +: 4] = col[n*4 +: 4];
                        end
                    end
                end
            end
        end
    endfunction

    task automatic drawTriangle(input CmdPkg::cmdWord_t bbS, input CmdPkg::cmdWord_t bbE,
                                input PixelPkg::color_t col, input PixelPkg::colorMask_t mask);
        writeReg(CmdPkg::RegBbStart, bbS);
        writeReg(CmdPkg::RegBbEnd, bbE);
        for (int i = 0; i < 3; i++) begin
            writeReg(CmdPkg::regIndex_t'(CmdPkg::RegW0 + i), triW[i]);
            writeReg(CmdPkg::regIndex_t'(CmdPkg::RegW0IncX + i), triIncX[i]);
            writeReg(CmdPkg::regIndex_t'(CmdPkg::RegW0IncY + i), triIncY[i]);
        end
        writeReg(CmdPkg::RegColor, col);
        writeReg(CmdPkg::RegColorMask, {12'h000, mask});
        sendOp(CmdPkg::OpStart);
        renderModel(bbS, bbE, col, mask);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////////////
    assert property (@(posedge aclk) disable iff (rst)
        (fbValid && !fbReady) |=> (fbValid && $stable(fbData) && $stable(fbLast)))
    else begin
        $display("Frame stream changed data or last while stalled");
        abortRun();
    end

    // Parser holds the stream back while anything runs
    assert property (@(posedge aclk) disable iff (rst)
        (u_Rasterix.rasterizerRunning || u_Rasterix.fbBusy) |-> !cmdReady)
    else begin
        $display("Command port was ready while a render, clear or commit was running");
        abortRun();
    end

    initial begin
        void'($urandom(32'h3441_89c4));
        aclk = 1'b0;
        rst = 1'b1;
        cmdValid = 1'b0;
        cmdLast = 1'b0;
        cmdData = '0;
        fbReady = 1'b0;
        gapsOn = 1'b0;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        @(negedge aclk);

        checkEqual("reset fbValid", 16'h0000, 16'(fbValid));
        checkEqual("reset cmdReady", 16'h0001, 16'(cmdReady));

        writeReg(CmdPkg::RegClearColor, 16'h1234);
        sendOp(CmdPkg::OpMemset);
        clearModel(16'h1234);
        sendOp(CmdPkg::OpCommit);
        collectFrame("clear", 1'b0);

        // Right triangle, covered where dx + dy <= 11
        triW    = '{16'd0, 16'd0, 16'd11};
        triIncX = '{16'd0, 16'd1, 16'hffff};
        triIncY = '{16'd1, 16'd0, 16'hffff};
        drawTriangle(16'h0202, 16'h0d0d, 16'hf0a5, 4'hf);
        sendOp(CmdPkg::OpCommit);
        collectFrame("render", 1'b0);

        // R and B only
        triW    = '{16'd0, 16'd20, 16'd3};
        triIncX = '{16'd2, 16'hffff, 16'd0};
        triIncY = '{16'hffff, 16'hffff, 16'd1};
        drawTriangle(16'h0104, 16'h0a0f, 16'h5a3c, 4'b1010);
        sendOp(CmdPkg::OpCommit);
        collectFrame("mask", 1'b0);

        sendOp(CmdPkg::OpCommit);
        collectFrame("stalls", 1'b1);

        // Second clear colour write waits behind the clear and must not leak into it
        gapsOn = 1'b1;
        writeReg(CmdPkg::RegClearColor, 16'h0ff0);
        sendOp(CmdPkg::OpMemset);
        clearModel(16'h0ff0);
        writeReg(CmdPkg::RegClearColor, 16'h7777);
        triW    = '{16'd8, 16'd8, 16'd20};
        triIncX = '{16'hffff, 16'd1, 16'hffff};
        triIncY = '{16'd1, 16'hffff, 16'hffff};
        drawTriangle(16'h0000, 16'h0f0f, 16'h9c61, 4'hf);
        sendOp(CmdPkg::OpCommit);
        collectFrame("holdoff", 1'b1);

        $display("Test OK");
        $finish;
    end

endmodule
